/* sim.f */
+incdir+common
common/readout_pkg.sv
common/stream_pkg.sv
readout_sequencer/readout_sequencer.sv
datamover/event_datamover.sv
source/event_out_fifo.sv
source/event_readout_top.sv
verif/readout_assert.sv
verif/readout_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the readout testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module readout_tb \
    -Mdir obj_dir -o readout_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench prints its summary
output=$(./obj_dir/readout_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1

/* verif/readout_tb.sv */
`include "readout_macros.svh"

module readout_tb;

    localparam int clk_period      = 40;
    localparam int num_events      = 5;
    // five cycles per beat is a generous bound, plus room for gathering
    localparam int watchdog_cycles = num_events * `READOUT_BEATS * 5 + 1000;

    logic                            aclk = 1'b0;
    logic                            memresetn;
    logic                            hdr_tvalid;
    stream_pkg::hdr_cmpl_t           hdr_tdata;
    logic                            hdr_tready;
    logic                            t0_tvalid;
    stream_pkg::tile_cmpl_t          t0_tdata;
    logic                            t0_tready;
    logic                            t1_tvalid;
    stream_pkg::tile_cmpl_t          t1_tdata;
    logic                            t1_tready;
    logic                            t2_tvalid;
    stream_pkg::tile_cmpl_t          t2_tdata;
    logic                            t2_tready;
    logic                            t3_tvalid;
    stream_pkg::tile_cmpl_t          t3_tdata;
    logic                            t3_tready;
    logic                            m_ctrl_tvalid;
    logic                            m_ctrl_tready = 1'b0;
    readout_pkg::ctrl_word_t         m_ctrl_tdata;
    logic                            m_data_tvalid;
    logic                            m_data_tready = 1'b0;
    logic [`READOUT_DATA_BITS-1:0]   m_data_tdata;
    logic                            m_data_tlast;
    logic [`READOUT_DATA_BITS/8-1:0] m_data_tkeep;
    logic                            mem_rd_en;
    logic [`READOUT_ADDR_BITS-1:0]   mem_rd_addr;
    logic [`READOUT_DATA_BITS-1:0]   mem_rd_data = '0;
    logic                            mem_rd_valid = 1'b0;
    logic                            any_err;

    int                            seed = 13;
    int                            rnd_mem;
    int                            rnd_bp;
    logic                          rd_busy = 1'b0;
    logic [1:0]                    rd_wait = 2'd0;
    logic [`READOUT_ADDR_BITS-1:0] rd_addr = '0;
    logic [31:0]                   ctrl_q[$];
    logic [64:0]                   beat_q[$];
    string                         test_name = "none";
    int                            error_count = 0;
    int                            errs_at_start = 0;
    int                            tests_passed = 0;
    int                            tests_failed = 0;

    event_readout_top u_dut (.*);

    bind event_readout_top readout_assert u_assert (.*);

    always #(clk_period / 2) aclk = ~aclk;

    // memory returns its own address, one read in flight, 1 to 4 cycles late
    always @(posedge aclk) begin
        if (!memresetn) begin
            mem_rd_valid <= 1'b0;
            rd_busy      <= 1'b0;
        end else begin
            mem_rd_valid <= 1'b0;
            if (mem_rd_en) begin
                rnd_mem = $random(seed);
                rd_addr <= mem_rd_addr;
                if (rnd_mem[1:0] == 2'd0) begin
                    mem_rd_valid <= 1'b1;
                    mem_rd_data  <= {32'd0, mem_rd_addr};
                end else begin
                    rd_busy <= 1'b1;
                    rd_wait <= rnd_mem[1:0];
                end
            end else if (rd_busy) begin
                if (rd_wait == 2'd1) begin
                    mem_rd_valid <= 1'b1;
                    mem_rd_data  <= {32'd0, rd_addr};
                    rd_busy      <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 2'd1;
                end
            end
        end
    end

    // random back-pressure on both output streams
    always @(posedge aclk) begin
        if (!memresetn) begin
            m_data_tready <= 1'b0;
            m_ctrl_tready <= 1'b0;
        end else begin
            rnd_bp = $random(seed);
            m_data_tready <= rnd_bp[0];
            m_ctrl_tready <= rnd_bp[1];
        end
    end

    task automatic check_value(string what, logic [64:0] expected, logic [64:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // scoreboard for control words and data beats
    always @(posedge aclk) begin
        if (memresetn && m_ctrl_tvalid && m_ctrl_tready) begin
            if (ctrl_q.size() == 0) begin
                $display("test %s got a control word that was not expected", test_name);
                error_count++;
            end else begin
                check_value("ctrl word", 65'(ctrl_q.pop_front()), 65'(m_ctrl_tdata));
            end
        end
        if (memresetn && m_data_tvalid && m_data_tready) begin
            if (beat_q.size() == 0) begin
                $display("test %s got a data beat that was not expected", test_name);
                error_count++;
            end else begin
                check_value("data beat", beat_q.pop_front(), {m_data_tlast, m_data_tdata});
            end
        end
    end

    function automatic int total_errors();
        return error_count + u_dut.u_assert.fail_count;
    endfunction

    task automatic begin_test(string name);
        test_name     = name;
        errs_at_start = total_errors();
    endtask

    task automatic end_test();
        if (total_errors() == errs_at_start) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed", test_name);
        end
    endtask

    task automatic raise_valids();
        logic [4:0] raised;
        logic [2:0] pick;
        raised = 5'd0;
        while (raised != 5'b11111) begin
            @(posedge aclk);
            pick = 3'($unsigned($random(seed)) % 5);
            if (!raised[pick]) begin
                raised[pick] = 1'b1;
                case (pick)
                    3'd0:    hdr_tvalid <= 1'b1;
                    3'd1:    t0_tvalid <= 1'b1;
                    3'd2:    t1_tvalid <= 1'b1;
                    3'd3:    t2_tvalid <= 1'b1;
                    default: t3_tvalid <= 1'b1;
                endcase
            end
        end
    endtask

    // queue the expected output, offer the completions, wait for the accept
    task automatic send_event(logic [12:0] upper, logic [31:0] tile_err);
        logic [31:0] saddr;
        saddr = {upper, `READOUT_START_OFFSET};
        ctrl_q.push_back({upper[11:0], 1'b0, `READOUT_BTT_BITS'(`READOUT_BEATS * 8)});
        for (int k = 0; k < `READOUT_BEATS; k++) begin
            beat_q.push_back({k == `READOUT_BEATS - 1, 32'd0, saddr + 32'(8 * k)});
        end
        @(posedge aclk);
        hdr_tdata <= {3'($random(seed)), upper, 8'h00};
        t0_tdata  <= {$random(seed), 32'd0};
        t1_tdata  <= {$random(seed), 32'd0};
        t2_tdata  <= {$random(seed), tile_err};
        t3_tdata  <= {$random(seed), 32'd0};
        raise_valids();
        do begin
            @(posedge aclk);
        end while (!(hdr_tvalid && hdr_tready));
        hdr_tvalid <= 1'b0;
        t0_tvalid  <= 1'b0;
        t1_tvalid  <= 1'b0;
        t2_tvalid  <= 1'b0;
        t3_tvalid  <= 1'b0;
    endtask

    task automatic wait_drain();
        while (ctrl_q.size() != 0 || beat_q.size() != 0) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);
    endtask

    task automatic check_reset_state();
        begin_test("reset");
        repeat (2) @(posedge aclk);
        check_value("outputs after reset", 65'd0,
                    65'({hdr_tready, m_ctrl_tvalid, m_data_tvalid, mem_rd_en, any_err}));
        end_test();
    endtask

    task automatic gather_one_event();
        begin_test("gather");
        send_event(13'h0a5, 32'd0);
        wait_drain();
        check_value("any_err", 65'd0, 65'(any_err));
        end_test();
    endtask

    task automatic run_back_to_back();
        begin_test("back_to_back");
        send_event(13'h001, 32'd0);
        send_event(13'h1f3, 32'd0);
        send_event(13'h07c, 32'd0);
        wait_drain();
        end_test();
    endtask

    task automatic flag_tile_error();
        begin_test("error_flag");
        send_event(13'h0e2, 32'h0000_0100);
        wait_drain();
        check_value("any_err", 65'd1, 65'(any_err));
        end_test();
    endtask

    initial begin
        memresetn  = 1'b0;
        hdr_tvalid = 1'b0;
        hdr_tdata  = '0;
        t0_tvalid  = 1'b0;
        t0_tdata   = '0;
        t1_tvalid  = 1'b0;
        t1_tdata   = '0;
        t2_tvalid  = 1'b0;
        t2_tdata   = '0;
        t3_tvalid  = 1'b0;
        t3_tdata   = '0;
        repeat (3) @(posedge aclk);
        memresetn <= 1'b1;
        check_reset_state();
        gather_one_event();
        run_back_to_back();
        flag_tile_error();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("run timed out after %0d cycles, the events did not complete",
                 watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* verif/readout_assert.sv */
`include "readout_macros.svh"

module readout_assert (
    input logic                            aclk,
    input logic                            memresetn,
    input logic                            hdr_tvalid,
    input stream_pkg::hdr_cmpl_t           hdr_tdata,
    input logic                            hdr_tready,
    input logic                            t0_tvalid,
    input stream_pkg::tile_cmpl_t          t0_tdata,
    input logic                            t0_tready,
    input logic                            t1_tvalid,
    input stream_pkg::tile_cmpl_t          t1_tdata,
    input logic                            t1_tready,
    input logic                            t2_tvalid,
    input stream_pkg::tile_cmpl_t          t2_tdata,
    input logic                            t2_tready,
    input logic                            t3_tvalid,
    input stream_pkg::tile_cmpl_t          t3_tdata,
    input logic                            t3_tready,
    input logic                            m_ctrl_tvalid,
    input logic                            m_ctrl_tready,
    input readout_pkg::ctrl_word_t         m_ctrl_tdata,
    input logic                            m_data_tvalid,
    input logic                            m_data_tready,
    input logic [`READOUT_DATA_BITS-1:0]   m_data_tdata,
    input logic                            m_data_tlast,
    input logic [`READOUT_DATA_BITS/8-1:0] m_data_tkeep,
    input logic                            mem_rd_en,
    input logic                            any_err
);

    int   fail_count = 0;
    logic all_valid;
    logic err_accept;

    assign all_valid = hdr_tvalid && t0_tvalid && t1_tvalid && t2_tvalid && t3_tvalid;

    // accepted completion carrying a nonzero error field
    assign err_accept = hdr_tready && all_valid &&
        ((|hdr_tdata.err) || (|t0_tdata.err) || (|t1_tdata.err) ||
         (|t2_tdata.err) || (|t3_tdata.err));

    reset_outputs_low: assert property (@(posedge aclk)
        !memresetn |=> !(hdr_tready || t0_tready || t1_tready || t2_tready || t3_tready ||
                         m_ctrl_tvalid || m_data_tvalid || mem_rd_en || any_err))
        else begin
            fail_count++;
            $error("outputs not low after reset");
        end

    readies_together: assert property (@(posedge aclk) disable iff (!memresetn)
        (t0_tready == hdr_tready) && (t1_tready == hdr_tready) &&
        (t2_tready == hdr_tready) && (t3_tready == hdr_tready))
        else begin
            fail_count++;
            $error("completion readies differ");
        end

    ready_after_all_valid: assert property (@(posedge aclk) disable iff (!memresetn)
        hdr_tready |-> $past(all_valid) && all_valid)
        else begin
            fail_count++;
            $error("ready raised before all streams were valid");
        end

    ready_single_cycle: assert property (@(posedge aclk) disable iff (!memresetn)
        hdr_tready |=> !hdr_tready)
        else begin
            fail_count++;
            $error("completion ready held for more than one cycle");
        end

    ctrl_stable: assert property (@(posedge aclk) disable iff (!memresetn)
        m_ctrl_tvalid && !m_ctrl_tready |=> m_ctrl_tvalid && $stable(m_ctrl_tdata))
        else begin
            fail_count++;
            $error("control word changed while stalled");
        end

    ctrl_fields: assert property (@(posedge aclk) disable iff (!memresetn)
        m_ctrl_tvalid |-> (m_ctrl_tdata.zero == 1'b0) &&
            (m_ctrl_tdata.btt == `READOUT_BTT_BITS'(`READOUT_BEATS * 8)))
        else begin
            fail_count++;
            $error("control word has a wrong byte count or zero bit");
        end

    data_stable: assert property (@(posedge aclk) disable iff (!memresetn)
        m_data_tvalid && !m_data_tready |=>
            m_data_tvalid && $stable(m_data_tdata) && $stable(m_data_tlast))
        else begin
            fail_count++;
            $error("data beat changed while stalled");
        end

    tkeep_ones: assert property (@(posedge aclk) disable iff (!memresetn)
        m_data_tvalid |-> (m_data_tkeep == '1))
        else begin
            fail_count++;
            $error("tkeep is not all ones");
        end

    // flag follows an error accept by exactly two cycles
    err_rise_timing: assert property (@(posedge aclk) disable iff (!memresetn)
        $rose(any_err) |-> $past(err_accept, 2))
        else begin
            fail_count++;
            $error("error flag rose without an error accept");
        end

    err_after_accept: assert property (@(posedge aclk) disable iff (!memresetn)
        $past(err_accept, 2) |-> any_err)
        else begin
            fail_count++;
            $error("error flag missing two cycles after accept");
        end

    err_sticky: assert property (@(posedge aclk) disable iff (!memresetn)
        any_err |=> any_err)
        else begin
            fail_count++;
            $error("error flag dropped before reset");
        end

endmodule

/* source/event_readout_top.sv */
`include "readout_macros.svh"

module event_readout_top (
    input  logic                            aclk,
    input  logic                            memresetn,
    input  logic                            hdr_tvalid,
    input  stream_pkg::hdr_cmpl_t           hdr_tdata,
    output logic                            hdr_tready,
    input  logic                            t0_tvalid,
    input  stream_pkg::tile_cmpl_t          t0_tdata,
    output logic                            t0_tready,
    input  logic                            t1_tvalid,
    input  stream_pkg::tile_cmpl_t          t1_tdata,
    output logic                            t1_tready,
    input  logic                            t2_tvalid,
    input  stream_pkg::tile_cmpl_t          t2_tdata,
    output logic                            t2_tready,
    input  logic                            t3_tvalid,
    input  stream_pkg::tile_cmpl_t          t3_tdata,
    output logic                            t3_tready,
    output logic                            m_ctrl_tvalid,
    input  logic                            m_ctrl_tready,
    output readout_pkg::ctrl_word_t         m_ctrl_tdata,
    output logic                            m_data_tvalid,
    input  logic                            m_data_tready,
    output logic [`READOUT_DATA_BITS-1:0]   m_data_tdata,
    output logic                            m_data_tlast,
    output logic [`READOUT_DATA_BITS/8-1:0] m_data_tkeep,
    output logic                            mem_rd_en,
    output logic [`READOUT_ADDR_BITS-1:0]   mem_rd_addr,
    input  logic [`READOUT_DATA_BITS-1:0]   mem_rd_data,
    input  logic                            mem_rd_valid,
    output logic                            any_err
);

    logic                    cmd_valid;
    readout_pkg::dm_cmd_t    cmd;
    logic                    cmd_ready;
    logic                    sts_valid;
    readout_pkg::dm_status_t sts;
    logic                    beat_valid;
    stream_pkg::data_beat_t  beat;
    logic                    fifo_room;
    stream_pkg::data_beat_t  fifo_dout;

    readout_sequencer u_sequencer (
        .aclk       (aclk),
        .memresetn  (memresetn),
        .hdr_valid  (hdr_tvalid),
        .hdr_data   (hdr_tdata),
        .hdr_ready  (hdr_tready),
        .t0_valid   (t0_tvalid),
        .t0_data    (t0_tdata),
        .t0_ready   (t0_tready),
        .t1_valid   (t1_tvalid),
        .t1_data    (t1_tdata),
        .t1_ready   (t1_tready),
        .t2_valid   (t2_tvalid),
        .t2_data    (t2_tdata),
        .t2_ready   (t2_tready),
        .t3_valid   (t3_tvalid),
        .t3_data    (t3_tdata),
        .t3_ready   (t3_tready),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .sts_valid  (sts_valid),
        .sts        (sts),
        .ctrl_valid (m_ctrl_tvalid),
        .ctrl       (m_ctrl_tdata),
        .ctrl_ready (m_ctrl_tready),
        .any_err    (any_err)
    );

    event_datamover u_datamover (
        .aclk         (aclk),
        .memresetn    (memresetn),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_ready    (cmd_ready),
        .sts_valid    (sts_valid),
        .sts          (sts),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_valid (mem_rd_valid),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .fifo_room    (fifo_room)
    );

    event_out_fifo u_outfifo (
        .aclk      (aclk),
        .memresetn (memresetn),
        .wr_en     (beat_valid),
        .din       (beat),
        .room      (fifo_room),
        .rd_valid  (m_data_tvalid),
        .dout      (fifo_dout),
        .rd_ready  (m_data_tready)
    );

    // fifo holds data plus tlast, every byte of a beat is valid
    assign m_data_tdata = fifo_dout.data;
    assign m_data_tlast = fifo_dout.last;
    assign m_data_tkeep = '1;

endmodule

/* source/event_out_fifo.sv */
`include "readout_macros.svh"

module event_out_fifo (
    input  logic                   aclk,
    input  logic                   memresetn,
    input  logic                   wr_en,
    input  stream_pkg::data_beat_t din,
    output logic                   room,
    output logic                   rd_valid,
    output stream_pkg::data_beat_t dout,
    input  logic                   rd_ready
);

    localparam int depth    = `READOUT_FIFO_DEPTH;
    localparam int ptr_bits = $clog2(depth);
    localparam logic [ptr_bits:0] full_count = (ptr_bits + 1)'(depth);
    // room means two free entries, one is held back for a read in flight
    localparam logic [ptr_bits:0] room_limit = (ptr_bits + 1)'(depth - 2);

    stream_pkg::data_beat_t mem [depth];
    logic [ptr_bits-1:0]    wr_ptr;
    logic [ptr_bits-1:0]    rd_ptr;
    logic [ptr_bits:0]      count;
    logic                   do_wr;
    logic                   do_rd;

    assign do_wr    = wr_en && (count != full_count);
    assign do_rd    = rd_valid && rd_ready;
    assign room     = (count <= room_limit);
    assign rd_valid = (count != '0);
    // head word falls through, no read latency
    assign dout     = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + ptr_bits'(1);
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + ptr_bits'(1);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + (ptr_bits + 1)'(1);
                2'b01:   count <= count - (ptr_bits + 1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* datamover/event_datamover.sv */
`include "readout_macros.svh"

module event_datamover (
    input  logic                          aclk,
    input  logic                          memresetn,
    input  logic                          cmd_valid,
    input  readout_pkg::dm_cmd_t          cmd,
    output logic                          cmd_ready,
    output logic                          sts_valid,
    output readout_pkg::dm_status_t       sts,
    output logic                          mem_rd_en,
    output logic [`READOUT_ADDR_BITS-1:0] mem_rd_addr,
    input  logic [`READOUT_DATA_BITS-1:0] mem_rd_data,
    input  logic                          mem_rd_valid,
    output logic                          beat_valid,
    output stream_pkg::data_beat_t        beat,
    input  logic                          fifo_room
);

    // each beat is 8 bytes so the low three bits of the byte count drop out
    localparam int cnt_bits = `READOUT_CMD_BTT_BITS - 3;

    logic                          busy;
    logic                          pending;
    logic                          incr;
    logic                          eof;
    logic [3:0]                    tag;
    logic [`READOUT_ADDR_BITS-1:0] addr;
    logic [cnt_bits-1:0]           rd_left;
    logic [cnt_bits-1:0]           ret_left;
    logic                          accept;
    logic                          issue;
    logic                          last_beat;

    assign cmd_ready = !busy;
    assign accept    = cmd_valid && !busy;

    // one read in flight, and the fifo keeps a spare slot for it
    assign issue = busy && !pending && (rd_left != '0) && fifo_room;

    assign beat_valid = mem_rd_valid && pending;
    assign last_beat  = beat_valid && (ret_left == cnt_bits'(1));
    assign beat.data  = mem_rd_data;
    assign beat.last  = eof && last_beat;

    always_comb begin
        sts        = '0;
        sts.okay   = 1'b1;
        sts.tag    = tag;
    end

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            busy      <= 1'b0;
            pending   <= 1'b0;
            mem_rd_en <= 1'b0;
            sts_valid <= 1'b0;
            rd_left   <= '0;
            ret_left  <= '0;
        end else begin
            mem_rd_en <= issue;
            // status goes out the cycle after the last beat
            sts_valid <= last_beat;
            if (accept) begin
                busy     <= 1'b1;
                rd_left  <= cmd.btt[`READOUT_CMD_BTT_BITS-1:3];
                ret_left <= cmd.btt[`READOUT_CMD_BTT_BITS-1:3];
            end else begin
                if (last_beat) begin
                    busy <= 1'b0;
                end
                if (issue) begin
                    rd_left <= rd_left - cnt_bits'(1);
                end
                if (beat_valid) begin
                    ret_left <= ret_left - cnt_bits'(1);
                end
            end
            if (issue) begin
                pending <= 1'b1;
            end else if (mem_rd_valid) begin
                pending <= 1'b0;
            end
        end
    end

    // address stepping and the latched command fields
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr <= cmd.saddr;
            incr <= cmd.incr;
            eof  <= cmd.eof;
            tag  <= cmd.tag;
        end else if (issue && incr) begin
            addr <= addr + `READOUT_ADDR_BITS'(8);
        end
        if (issue) begin
            mem_rd_addr <= addr;
        end
    end

endmodule

/* readout_sequencer/readout_sequencer.sv */
`include "readout_macros.svh"

module readout_sequencer (
    input  logic                    aclk,
    input  logic                    memresetn,
    input  logic                    hdr_valid,
    input  stream_pkg::hdr_cmpl_t   hdr_data,
    output logic                    hdr_ready,
    input  logic                    t0_valid,
    input  stream_pkg::tile_cmpl_t  t0_data,
    output logic                    t0_ready,
    input  logic                    t1_valid,
    input  stream_pkg::tile_cmpl_t  t1_data,
    output logic                    t1_ready,
    input  logic                    t2_valid,
    input  stream_pkg::tile_cmpl_t  t2_data,
    output logic                    t2_ready,
    input  logic                    t3_valid,
    input  stream_pkg::tile_cmpl_t  t3_data,
    output logic                    t3_ready,
    output logic                    cmd_valid,
    output readout_pkg::dm_cmd_t    cmd,
    input  logic                    cmd_ready,
    input  logic                    sts_valid,
    input  readout_pkg::dm_status_t sts,
    output logic                    ctrl_valid,
    output readout_pkg::ctrl_word_t ctrl,
    input  logic                    ctrl_ready,
    output logic                    any_err
);

    localparam logic [`READOUT_BTT_BITS-1:0] event_btt =
        `READOUT_BTT_BITS'(`READOUT_BEATS * 8);

    readout_pkg::seq_state_t state;
    logic                    cmpl_ready;
    logic                    all_valid;
    logic [12:0]             upper_addr;
    logic [3:0]              tag;
    logic                    sts_hit;
    logic                    sts_seen;
    logic [4:0]              err_hit;
    logic [4:0]              err_seen;

    assign all_valid = hdr_valid && t0_valid && t1_valid && t2_valid && t3_valid;

    // all five streams are accepted on the same cycle
    assign hdr_ready = cmpl_ready;
    assign t0_ready  = cmpl_ready;
    assign t1_ready  = cmpl_ready;
    assign t2_ready  = cmpl_ready;
    assign t3_ready  = cmpl_ready;

    // error fields of each accepted completion
    assign err_hit[0] = hdr_valid && cmpl_ready && (|hdr_data.err);
    assign err_hit[1] = t0_valid && cmpl_ready && (|t0_data.err);
    assign err_hit[2] = t1_valid && cmpl_ready && (|t1_data.err);
    assign err_hit[3] = t2_valid && cmpl_ready && (|t2_data.err);
    assign err_hit[4] = t3_valid && cmpl_ready && (|t3_data.err);

    // only the status for the current event's tag ends it
    assign sts_hit = sts_valid && (sts.tag == tag);

    assign cmd_valid = (state == readout_pkg::seq_issue_cmd);

    always_comb begin
        cmd       = '0;
        cmd.tag   = tag;
        cmd.saddr = {upper_addr, `READOUT_START_OFFSET};
        cmd.eof   = 1'b1;
        cmd.incr  = 1'b1;
        cmd.btt   = `READOUT_CMD_BTT_BITS'(event_btt);
    end

    // top bit of the upper address is not carried in the control word
    always_comb begin
        ctrl.upper_addr = upper_addr[11:0];
        ctrl.zero       = 1'b0;
        ctrl.btt        = event_btt;
    end

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            state      <= readout_pkg::seq_idle;
            cmpl_ready <= 1'b0;
            ctrl_valid <= 1'b0;
            sts_seen   <= 1'b0;
            tag        <= 4'd0;
        end else begin
            cmpl_ready <= (state == readout_pkg::seq_idle) && all_valid;
            // a status that shows up before done is remembered
            if (state == readout_pkg::seq_done) begin
                sts_seen <= 1'b0;
            end else if (sts_hit) begin
                sts_seen <= 1'b1;
            end
            case (state)
                readout_pkg::seq_idle: begin
                    if (all_valid) begin
                        state <= readout_pkg::seq_issue_cmd;
                    end
                end
                readout_pkg::seq_issue_cmd: begin
                    if (cmd_ready) begin
                        state      <= readout_pkg::seq_issue_ctrl;
                        ctrl_valid <= 1'b1;
                    end
                end
                readout_pkg::seq_issue_ctrl: begin
                    if (ctrl_ready) begin
                        state      <= readout_pkg::seq_done;
                        ctrl_valid <= 1'b0;
                    end
                end
                default: begin
                    if (sts_hit || sts_seen) begin
                        state <= readout_pkg::seq_idle;
                        tag   <= tag + 4'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if ((state == readout_pkg::seq_idle) && all_valid) begin
            upper_addr <= hdr_data.upper_addr;
        end
    end

    // two stages: per-stream sticky bit, then the combined flag
    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            err_seen <= 5'd0;
            any_err  <= 1'b0;
        end else begin
            err_seen <= err_seen | err_hit;
            any_err  <= |err_seen;
        end
    end

endmodule

/* common/stream_pkg.sv */
`include "readout_macros.svh"

package stream_pkg;

    // upper address sits at bits 20:8 of the header word
    typedef struct packed {
        logic [2:0]  spare;
        logic [12:0] upper_addr;
        logic [7:0]  err;
    } hdr_cmpl_t;

    typedef struct packed {
        logic [31:0] info;
        logic [31:0] err;
    } tile_cmpl_t;

    // one beat of the output stream, tkeep is implied all ones
    typedef struct packed {
        logic                          last;
        logic [`READOUT_DATA_BITS-1:0] data;
    } data_beat_t;

endpackage

/* common/readout_pkg.sv */
`include "readout_macros.svh"

package readout_pkg;

    // datamover command, upper byte carries the tag
    typedef struct packed {
        logic [3:0]                      rsvd;
        logic [3:0]                      tag;
        logic [`READOUT_ADDR_BITS-1:0]   saddr;
        logic                            drr;
        logic                            eof;
        logic [5:0]                      dsa;
        logic                            incr;
        logic [`READOUT_CMD_BTT_BITS-1:0] btt;
    } dm_cmd_t;

    // control word for the fragment generator
    typedef struct packed {
        logic [11:0]                 upper_addr;
        logic                        zero;
        logic [`READOUT_BTT_BITS-1:0] btt;
    } ctrl_word_t;

    typedef struct packed {
        logic       okay;
        logic       slverr;
        logic       decerr;
        logic       interr;
        logic [3:0] tag;
    } dm_status_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue_cmd,
        seq_issue_ctrl,
        seq_done
    } seq_state_t;

endpackage

/* common/readout_macros.svh */
`ifndef READOUT_MACROS_SVH
`define READOUT_MACROS_SVH

// byte offset of the event buffer inside one upper-address page
`define READOUT_START_OFFSET 19'h03E00

// 64-bit beats per event, byte count is this times 8
`define READOUT_BEATS 16

// output fifo entries, keep it a power of two
`define READOUT_FIFO_DEPTH 32

// word widths
`define READOUT_BTT_BITS 19
`define READOUT_CMD_BTT_BITS 23
`define READOUT_ADDR_BITS 32
`define READOUT_DATA_BITS 64

`endif
